// File: bench/rv_core_golden.txt
# T name | P byte_addr word | E pc rd wdata, where rd 0 means no write | H halt expected
# All numbers are hex
T alu_lui_x0
P 00 ff900093
P 04 00100113
P 08 401101b3
P 0c 4020d233
P 10 0020c2b3
P 14 0020a333
P 18 0020b3b3
P 1c abcde437
P 20 00500013
P 24 000404b3
P 28 00147533
P 2c 002465b3
P 30 00100073
E 00 1 fffffff9
E 04 2 00000001
E 08 3 00000008
E 0c 4 fffffffc
E 10 5 fffffff8
E 14 6 00000001
E 18 7 00000000
E 1c 8 abcde000
E 20 0 00000000
E 24 9 abcde000
E 28 a abcde000
E 2c b abcde001
E 30 0 00000000
H
T mem_branch_halt
P 00 30000093
P 04 fab00113
P 08 0020a023
P 0c 0010a223
P 10 0000a183
P 14 0040a203
P 18 00418463
P 1c 00218463
P 20 00100293
P 24 00219463
P 28 00419463
P 2c 00100293
P 30 00100073
E 00 1 00000300
E 04 2 ffffffab
E 08 0 00000000
E 0c 0 00000000
E 10 3 ffffffab
E 14 4 00000300
E 18 0 00000000
E 1c 0 00000000
E 24 0 00000000
E 28 0 00000000
E 30 0 00000000
H

// File: verilog.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/core_pkg.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/sys_mem.sv
rtl/core_control.sv
rtl/rv_core_top.sv
bench/rv_core_assert.sv
bench/rv_core_checker.sv
bench/tb_rv_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the core testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_rv_core \
    --Mdir obj_dir -o tb_rv_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Let assertion errors count up so the testbench reaches its verdict
output=$(./obj_dir/tb_rv_core +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// File: bench/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core import rv_isa_pkg::*; import core_pkg::*; ();

    logic    CLK;
    logic    RST;
    logic    load_en;
    word_t   load_addr;
    word_t   load_data;
    retire_t retire;
    logic    retire_valid;
    logic    halted;

    // Parsed golden records, tagged with the index of their test
    string    test_name [$];
    bit       test_halt [$];
    int       prog_test [$];
    word_t    prog_addr [$];
    word_t    prog_word [$];
    int       exp_test [$];
    word_t    exp_pc [$];
    reg_idx_t exp_rd [$];
    word_t    exp_wdata [$];
    int       cycle_limit;
    int       run_cycles;
    int       setup_errors;

    rv_core_top rv_core_top_inst (
        .CLK          (CLK),
        .RST          (RST),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .retire       (retire),
        .retire_valid (retire_valid),
        .halted       (halted)
    );

    rv_core_checker checker_inst (
        .CLK          (CLK),
        .RST          (RST),
        .retire       (retire),
        .retire_valid (retire_valid),
        .halted       (halted)
    );

    always #5 CLK = ~CLK;

    // Only cycles out of reset count toward the limit
    always @(posedge CLK) begin
        if (!RST) begin
            run_cycles = run_cycles + 1;
            if (run_cycles > cycle_limit) begin
                $display("TIMEOUT: no halt within %0d cycles out of reset", cycle_limit);
                $display("sim failed");
                $finish;
            end
        end
    end

    function automatic string trim_end(input string s);
        string r;
        r = s;
        while (r.len() > 0 && (r[r.len()-1] == "\n" || r[r.len()-1] == "\r" ||
                               r[r.len()-1] == " ")) begin
            r = r.substr(0, r.len() - 2);
        end
        return r;
    endfunction

    // Word that a test loads at a byte address, last one wins
    function automatic bit program_word_at(input int t, input word_t addr, output word_t w);
        bit found;
        found = 1'b0;
        w     = '0;
        foreach (prog_word[i]) begin
            if (prog_test[i] == t && prog_addr[i] == addr) begin
                w     = prog_word[i];
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic read_golden();
        int    fd;
        int    n;
        int    cur;
        string line;
        word_t a;
        word_t b;
        word_t c;
        cur = -1;
        fd  = $fopen("bench/rv_core_golden.txt", "r");
        if (fd == 0) begin
            setup_errors++;
            $display("ERROR: the golden file could not be opened");
            return;
        end
        while ($fgets(line, fd) > 0) begin
            n = 0;
            case (line[0])
                "T": begin
                    test_name.push_back(trim_end(line.substr(2, line.len() - 1)));
                    test_halt.push_back(1'b0);
                    cur = test_name.size() - 1;
                    n   = -1;
                end
                "P": begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                    if (n == 2 && cur >= 0) begin
                        prog_test.push_back(cur);
                        prog_addr.push_back(a);
                        prog_word.push_back(b);
                        n = -1;
                    end
                end
                "E": begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
                    if (n == 3 && cur >= 0) begin
                        exp_test.push_back(cur);
                        exp_pc.push_back(a);
                        exp_rd.push_back(b[4:0]);
                        exp_wdata.push_back(c);
                        n = -1;
                    end
                end
                "H": begin
                    if (cur >= 0) begin
                        test_halt[cur] = 1'b1;
                        n = -1;
                    end
                end
                "#", "\n", "\r", " ": n = -1;   // Comments and blank lines
                default: n = 0;
            endcase
            if (n != -1) begin
                setup_errors++;
                $display("ERROR: golden line not understood: %s", trim_end(line));
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int t);
        word_t instr_exp;
        @(posedge CLK);
        #1;
        RST = 1'b1;
        checker_inst.begin_test(test_name[t]);
        foreach (exp_pc[i]) begin
            if (exp_test[i] == t) begin
                if (!program_word_at(t, exp_pc[i], instr_exp)) begin
                    setup_errors++;
                    $display("ERROR: test %s expects a retire at pc %h outside its program",
                             test_name[t], exp_pc[i]);
                end
                checker_inst.add_expect(exp_pc[i], instr_exp, exp_rd[i], exp_wdata[i]);
            end
        end
        repeat (4) begin
            @(posedge CLK);
            #1;
        end
        foreach (prog_word[i]) begin
            if (prog_test[i] == t) begin
                load_en   = 1'b1;
                load_addr = prog_addr[i];
                load_data = prog_word[i];
                @(posedge CLK);
                #1;
            end
        end
        load_en = 1'b0;
        RST     = 1'b0;
        @(negedge CLK);             // halted is a level, look mid-cycle
        while (!halted) begin
            @(negedge CLK);
        end
        repeat (3) @(negedge CLK);  // Window for stray retires after halt
    endtask

    initial begin
        CLK          = 1'b0;
        RST          = 1'b1;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        run_cycles   = 0;
        cycle_limit  = 0;
        setup_errors = 0;
        read_golden();
        cycle_limit = exp_pc.size() + 20 * test_name.size();
        for (int t = 0; t < test_name.size(); t++) begin
            if (test_halt[t]) begin
                run_test(t);
            end else begin
                setup_errors++;
                $display("ERROR: test %s has no halt record", test_name[t]);
            end
        end
        $display("tests %0d, run %0d, failed %0d, errors %0d, assertion failures %0d",
                 test_name.size(), checker_inst.tests_done, checker_inst.tests_failed,
                 checker_inst.error_count + setup_errors,
                 rv_core_top_inst.rv_core_assert_inst.fail_count);
        if (setup_errors == 0 && test_name.size() > 0 && checker_inst.error_count == 0 &&
            checker_inst.tests_failed == 0 && checker_inst.tests_done == test_name.size() &&
            rv_core_top_inst.rv_core_assert_inst.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: bench/rv_core_checker.sv
`timescale 1ns/10ps

module rv_core_checker import rv_isa_pkg::*; import core_pkg::*; (
    input logic    CLK,
    input logic    RST,
    input retire_t retire,
    input logic    retire_valid,
    input logic    halted
);

    word_t    exp_pc [$];
    word_t    exp_instr [$];
    reg_idx_t exp_rd [$];
    word_t    exp_wdata [$];
    string    name;
    bit       active = 1'b0;      // Set once the first test is loaded
    bit       halt_seen = 1'b0;
    int       next_idx = 0;
    int       test_errors = 0;
    int       error_count = 0;
    int       tests_done = 0;
    int       tests_failed = 0;

    task automatic begin_test(input string test);
        name = test;
        exp_pc.delete();
        exp_instr.delete();
        exp_rd.delete();
        exp_wdata.delete();
        active      = 1'b1;
        halt_seen   = 1'b0;
        next_idx    = 0;
        test_errors = 0;
    endtask

    task automatic add_expect(input word_t pc, input word_t instr, input reg_idx_t rd,
                              input word_t wdata);
        exp_pc.push_back(pc);
        exp_instr.push_back(instr);
        exp_rd.push_back(rd);
        exp_wdata.push_back(wdata);
    endtask

    task automatic report_mismatch(input string sig, input word_t expected, input word_t actual);
        $display("CHECK FAILED %s: %s expected %h actual %h", name, sig, expected, actual);
        test_errors++;
        error_count++;
    endtask

    task automatic report_problem(input string what);
        $display("ERROR in %s: %s", name, what);
        test_errors++;
        error_count++;
    endtask

    task automatic compare_retire();
        reg_idx_t rd;
        rd = exp_rd[next_idx];
        if (retire.pc !== exp_pc[next_idx])
            report_mismatch("retire.pc", exp_pc[next_idx], retire.pc);
        if (retire.instr !== exp_instr[next_idx])
            report_mismatch("retire.instr", exp_instr[next_idx], retire.instr);
        if (retire.rd !== rd)
            report_mismatch("retire.rd", word_t'(rd), word_t'(retire.rd));
        if (retire.reg_write !== (rd != '0))  // rd 0 in the list means no write
            report_mismatch("retire.reg_write", word_t'(rd != '0), word_t'(retire.reg_write));
        if (rd != '0 && retire.wdata !== exp_wdata[next_idx])
            report_mismatch("retire.wdata", exp_wdata[next_idx], retire.wdata);
        next_idx++;
    endtask

    // Sample mid-cycle, where the combinational retire record is settled
    always @(negedge CLK) begin
        if (!RST && active) begin
            if (retire_valid) begin
                if (halt_seen)
                    report_problem($sformatf("instruction at pc %h retired after halt", retire.pc));
                else if (next_idx >= exp_pc.size())
                    report_problem($sformatf("unexpected extra retire at pc %h", retire.pc));
                else
                    compare_retire();
            end
            if (halted && !halt_seen) begin
                halt_seen = 1'b1;
                if (next_idx < exp_pc.size())
                    report_problem($sformatf("core halted with %0d of %0d retires missing",
                                             exp_pc.size() - next_idx, exp_pc.size()));
                tests_done++;
                if (test_errors != 0)
                    tests_failed++;
                $display("test %s: %s, %0d retires, %0d errors", name,
                         (test_errors == 0) ? "ok" : "FAILED", next_idx, test_errors);
            end
        end
    end

endmodule

// File: bench/rv_core_assert.sv
`timescale 1ns/10ps

module rv_core_assert import core_pkg::*; (
    input logic  CLK,
    input logic  RST,
    input ctrl_t ctrl,
    input word_t rs1_data,
    input word_t rs2_data,
    input logic  retire_valid,
    input logic  halted
);

    int unsigned fail_count = 0;

    // A halted core stays halted until reset and retires nothing
    assert property (@(posedge CLK) disable iff (RST)
        (halted || $past(halted)) |-> (halted && !retire_valid))
        else begin
            $error("retire_valid high while halted, or halted dropped before reset");
            fail_count++;
        end

    // x0 reads stay zero right after a dropped x0 write
    assert property (@(posedge CLK) disable iff (RST)
        (ctrl.reg_write && ctrl.rd == '0) |=>
            (ctrl.rs1 != '0 || rs1_data == '0) && (ctrl.rs2 != '0 || rs2_data == '0))
        else begin
            $error("a read of x0 returned nonzero after a write to x0");
            fail_count++;
        end

    assert property (@(posedge CLK) $fell(RST) |-> !retire_valid)  // st_reset cycle
        else begin
            $error("retire_valid high in the first cycle after reset");
            fail_count++;
        end

endmodule

bind rv_core_top rv_core_assert rv_core_assert_inst (
    .CLK          (CLK),
    .RST          (RST),
    .ctrl         (ctrl),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .retire_valid (retire_valid),
    .halted       (halted)
);

// File: rtl/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top import core_pkg::*; (
    input  logic    CLK,
    input  logic    RST,
    input  logic    load_en,
    input  word_t   load_addr,
    input  word_t   load_data,
    output retire_t retire,
    output logic    retire_valid,
    output logic    halted
);

    ctrl_t ctrl;
    word_t fetch_addr;
    word_t instr;
    word_t imm;
    word_t wdata;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_result;
    word_t mem_rdata;   // Data port read, ahead of write-back select

    core_control core_control_inst (
        .CLK          (CLK),
        .RST          (RST),
        .instr        (instr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_result   (alu_result),
        .load_data    (mem_rdata),
        .fetch_addr   (fetch_addr),
        .ctrl         (ctrl),
        .imm          (imm),
        .wdata        (wdata),
        .retire       (retire),
        .retire_valid (retire_valid),
        .halted       (halted)
    );

    alu alu_inst (
        .op     (ctrl.alu_op),
        .a      (rs1_data),
        .b      (imm),
        .result (alu_result)
    );

    reg_file reg_file_inst (
        .CLK      (CLK),
        .RST      (RST),
        .ctrl     (ctrl),
        .wdata    (wdata),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // Store address straight from the ALU, store data from rs2
    sys_mem sys_mem_inst (
        .CLK          (CLK),
        .load_en      (load_en && RST),   // Program load only in reset
        .load_addr    (load_addr),
        .load_data_in (load_data),
        .fetch_addr   (fetch_addr),
        .instr        (instr),
        .ctrl         (ctrl),
        .data_addr    (alu_result),
        .store_data   (rs2_data),
        .load_data    (mem_rdata)
    );

endmodule

// File: rtl/core_control.sv
`timescale 1ns/10ps
`include "core_config.svh"

module core_control import rv_isa_pkg::*; import core_pkg::*; (
    input  logic    CLK,
    input  logic    RST,
    input  word_t   instr,
    input  word_t   rs1_data,
    input  word_t   rs2_data,
    input  word_t   alu_result,
    input  word_t   load_data,
    output word_t   fetch_addr,
    output ctrl_t   ctrl,
    output word_t   imm,        // ALU operand B
    output word_t   wdata,
    output retire_t retire,
    output logic    retire_valid,
    output logic    halted
);

    core_state_e state;
    word_t       pc;
    word_t       next_pc;
    opcode_t     opcode;
    funct3_t     funct3;
    funct7_t     funct7;
    word_t       imm_i;
    word_t       imm_s;
    word_t       imm_b;
    word_t       imm_u;
    word_t       imm_sel;
    ctrl_t       dec;
    logic        is_branch;
    logic        is_ebreak;
    logic        branch_taken;
    logic        run;
    logic        rd_written;

    // Shared funct3 map for register and immediate ALU ops
    function automatic alu_op_e alu_decode(input funct3_t f3, input logic alt,
                                           input logic is_reg);
        case (f3)
            F3_ADD_SUB: alu_decode = (alt && is_reg) ? alu_sub : alu_add;
            F3_SLL:     alu_decode = alu_sll;
            F3_SLT:     alu_decode = alu_slt;
            F3_SLTU:    alu_decode = alu_sltu;
            F3_XOR:     alu_decode = alu_xor;
            F3_SRL_SRA: alu_decode = alt ? alu_sra : alu_srl;
            F3_OR:      alu_decode = alu_or;
            default:    alu_decode = alu_and;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        dec        = '0;
        dec.alu_op = alu_add;
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];
        dec.rd     = instr[11:7];
        imm_sel    = imm_i;
        is_branch  = 1'b0;
        is_ebreak  = 1'b0;
        case (opcode)
            OPC_R_TYPE: begin
                if (funct7 == F7_BASE || funct7 == F7_ALT) begin
                    dec.alu_op    = alu_decode(funct3, funct7 == F7_ALT, 1'b1);
                    dec.reg_write = 1'b1;
                end
            end
            OPC_I_TYPE: begin
                dec.alu_op      = alu_decode(funct3, funct7 == F7_ALT, 1'b0);
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
            end
            OPC_LOAD: begin
                dec.alu_src_imm = 1'b1;             // Address is rs1 + imm
                dec.reg_write   = (funct3 == F3_WORD);
                dec.wb_from_mem = 1'b1;
            end
            OPC_STORE: begin
                dec.alu_src_imm = 1'b1;
                dec.mem_write   = (funct3 == F3_WORD);
                imm_sel         = imm_s;
            end
            OPC_BRANCH: begin
                dec.alu_op = alu_sub;
                is_branch  = 1'b1;
            end
            OPC_LUI: begin
                dec.alu_op      = alu_pass_b;
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
                imm_sel         = imm_u;
            end
            OPC_SYSTEM: is_ebreak = (instr == INSTR_EBREAK);
            default: ;                              // Retires as a no-op
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  branch_taken = (rs1_data == rs2_data);
            F3_BNE:  branch_taken = (rs1_data != rs2_data);
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        if (is_ebreak) begin
            next_pc = pc;                           // Freeze on halt
        end else if (is_branch && branch_taken) begin
            next_pc = pc + imm_b;
        end else begin
            next_pc = pc + word_t'(4);
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= st_reset;
            pc    <= `CORE_RESET_PC;
        end else begin
            case (state)
                st_reset: state <= st_run;
                st_run: begin
                    pc <= next_pc;
                    if (is_ebreak) begin
                        state <= st_halt;
                    end
                end
                default: state <= st_halt;
            endcase
        end
    end

    assign run          = (state == st_run);
    assign retire_valid = run;
    assign halted       = (state == st_halt);
    assign fetch_addr   = pc;

    // Writes only commit while running
    always_comb begin
        ctrl           = dec;
        ctrl.reg_write = dec.reg_write && run;
        ctrl.mem_write = dec.mem_write && run;
    end

    assign imm   = dec.alu_src_imm ? imm_sel : rs2_data;
    assign wdata = dec.wb_from_mem ? load_data : alu_result;

    assign rd_written = dec.reg_write && (dec.rd != '0);

    always_comb begin
        retire.pc        = pc;
        retire.instr     = instr;
        retire.reg_write = rd_written;
        retire.rd        = rd_written ? dec.rd : '0;
        retire.wdata     = rd_written ? wdata : '0;
    end

endmodule

// File: rtl/sys_mem.sv
`timescale 1ns/10ps
`include "core_config.svh"

module sys_mem import core_pkg::*; (
    input  logic  CLK,
    input  logic  load_en,
    input  word_t load_addr,      // Byte address
    input  word_t load_data_in,
    input  word_t fetch_addr,
    output word_t instr,
    input  ctrl_t ctrl,
    input  word_t data_addr,
    input  word_t store_data,
    output word_t load_data
);

    localparam int IDX_BITS = $clog2(`CORE_MEM_WORDS);

    typedef logic [IDX_BITS-1:0] mem_idx_t;

    word_t    mem [`CORE_MEM_WORDS];
    mem_idx_t fetch_idx;
    mem_idx_t data_idx;
    mem_idx_t load_idx;

    // Word index from a byte address, upper bits wrap
    assign fetch_idx = fetch_addr[IDX_BITS+1:2];
    assign data_idx  = data_addr[IDX_BITS+1:2];
    assign load_idx  = load_addr[IDX_BITS+1:2];

    assign instr     = mem[fetch_idx];
    assign load_data = mem[data_idx];

    // Program load only happens in reset, stores only while running
    always_ff @(posedge CLK) begin
        if (load_en) begin
            mem[load_idx] <= load_data_in;
        end else if (ctrl.mem_write) begin
            mem[data_idx] <= store_data;
        end
    end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/10ps

module reg_file import core_pkg::*; (
    input  logic  CLK,
    input  logic  RST,
    input  ctrl_t ctrl,
    input  word_t wdata,
    output word_t rs1_data,
    output word_t rs2_data
);

    // x1 to x31, x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write && ctrl.rd != '0) begin
            regs[ctrl.rd] <= wdata;     // Writes to x0 dropped
        end
    end

    // Combinational reads, x0 always zero
    assign rs1_data = (ctrl.rs1 == '0) ? '0 : regs[ctrl.rs1];
    assign rs2_data = (ctrl.rs2 == '0) ? '0 : regs[ctrl.rs2];

endmodule

// File: rtl/alu.sv
`timescale 1ns/10ps

module alu import rv_isa_pkg::*; import core_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];    // Shift amount from the low five bits
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = word_t'(lt_signed);
            alu_sltu:   result = word_t'(lt_unsigned);
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = word_t'($signed(a) >>> shamt);  // Sign fill
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;                          // lui
            default:    result = '0;
        endcase
    end

endmodule

// File: rtl/core_pkg.sv
`include "core_config.svh"

package core_pkg;

    import rv_isa_pkg::*;

    typedef logic [`CORE_XLEN-1:0] word_t;

    // Decoded control for one instruction
    typedef struct packed {
        alu_op_e  alu_op;
        logic     alu_src_imm;  // Operand B from the immediate
        logic     reg_write;
        logic     mem_write;
        logic     wb_from_mem;  // Write back the loaded word
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
    } ctrl_t;

    // What commits at the end of a run cycle
    typedef struct packed {
        word_t    pc;
        word_t    instr;
        reg_idx_t rd;         // Zero when nothing is written
        logic     reg_write;
        word_t    wdata;
    } retire_t;

    typedef enum logic [1:0] {
        st_reset,
        st_run,
        st_halt
    } core_state_e;

endpackage

// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;
    typedef logic [4:0] reg_idx_t;

    // Major opcodes of the supported subset
    localparam opcode_t OPC_R_TYPE = 7'b0110011;
    localparam opcode_t OPC_I_TYPE = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // ALU funct3 encodings, shared by R-type and I-type
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam funct3_t F3_WORD = 3'b010;   // lw and sw width
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;   // sub and sra

    localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

endpackage

// File: rtl/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Datapath and address width in bits
`define CORE_XLEN 32

// Depth of the unified memory in 32-bit words
// Any power of two works, the byte address is cut to fit
`define CORE_MEM_WORDS 256

// First fetch address once reset is released
`define CORE_RESET_PC 32'h0000_0000

`endif
